//--- Makefile
SIM  := obj_dir/VexecuteUnitTb
SRCS := $(shell grep -v '^+' tb.f) verification/execModel.svh

.PHONY: all run clean

all: run

$(SIM): tb.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f tb.f --top-module executeUnitTb -o VexecuteUnitTb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- rtl/execPkg.sv
package execPkg;

    //////////////////////////////
    // Widths and bit positions
    //////////////////////////////
    localparam int dataWidth  = 32;
    localparam int immWidth   = 24;
    localparam int srWidth    = 8;
    localparam int shiftWidth = 5;  // Immediate bits used as shift amount

    localparam int carryBit   = 7;  // C flag in status register
    localparam int cmpHiBit   = 1;  // Compare flag, high half
    localparam int cmpLoBit   = 0;  // Compare flag, low half

    //////////////////////////////
    // Instruction encodings
    //////////////////////////////
    typedef enum logic [7:0] {
        opAddIm  = 8'd1,
        opAddImC = 8'd2,
        opAdd    = 8'd3,
        opAddC   = 8'd4,
        opSubIm  = 8'd5,
        opSubImC = 8'd6,
        opSub    = 8'd7,
        opSubC   = 8'd8,
        opShl    = 8'd13,
        opShlC   = 8'd14,
        opShr    = 8'd15,
        opShrC   = 8'd16,
        opAnd    = 8'd17,
        opNand   = 8'd18,
        opOr     = 8'd19,
        opNor    = 8'd20,
        opXor    = 8'd21,
        opXnor   = 8'd22,
        opRjp    = 8'd23,
        opJp     = 8'd24,
        opJeq    = 8'd26,
        opJg     = 8'd27,
        opJl     = 8'd28,
        opJgeq   = 8'd29,
        opJleq   = 8'd30,
        opCp     = 8'd31,
        opCpi    = 8'd33,
        opLdi    = 8'd37,
        opMov    = 8'd38,
        opSor    = 8'd44,
        opSand   = 8'd45,
        opSld    = 8'd46,
        opNop    = 8'd255
    } opcode_e;

    // Which part of the datapath handles the opcode
    typedef enum logic [2:0] {
        clsArith,
        clsLogic,
        clsShift,
        clsCompare,
        clsJump,
        clsStatus,
        clsMove,
        clsNop
    } opClass_e;

    typedef enum logic [2:0] {
        pcHold = 3'd0,
        pcInc  = 3'd1,
        pcDec  = 3'd2,
        pcSet  = 3'd3,
        pcAdd  = 3'd4   // PC += target
    } pcOp_e;

endpackage

//--- rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage
(
    input  logic    clk,
    input  logic    rst,
    operandIf.sink  up,
    resultIf.source down
);

    logic                            isSub;
    logic                            useCarry;
    logic                            carryIn;
    logic                            srCarry;
    logic [execPkg::dataWidth:0]     addSum;     // Carry in top bit
    logic [execPkg::dataWidth:0]     subDiff;    // Borrow in top bit
    logic [execPkg::shiftWidth-1:0]  shAmt;
    logic [execPkg::dataWidth+1:0]   shlWide;
    logic [execPkg::dataWidth+1:0]   shrWide;
    logic [execPkg::dataWidth-1:0]   result;
    logic [execPkg::srWidth-1:0]     srNext;

    assign isSub    = up.opcode inside {execPkg::opSubIm, execPkg::opSubImC,
                                        execPkg::opSub, execPkg::opSubC};
    assign useCarry = up.opcode inside {execPkg::opAddImC, execPkg::opAddC,
                                        execPkg::opSubImC, execPkg::opSubC};
    assign srCarry  = up.srIn[execPkg::carryBit];
    assign carryIn  = useCarry && srCarry;

    //////////////////////////////
    // Adder and subtractor
    //////////////////////////////
    assign addSum  = {1'b0, up.a} + {1'b0, up.op2} + {{execPkg::dataWidth{1'b0}}, carryIn};
    assign subDiff = {1'b0, up.a} - {1'b0, up.op2} - {{execPkg::dataWidth{1'b0}}, carryIn};

    // Carry rides one position beyond the word on each side;
    // the shifted word lands in bits dataWidth:1
    assign shAmt   = up.op2[execPkg::shiftWidth-1:0];
    assign shlWide = {1'b0, up.a, srCarry} << shAmt;
    assign shrWide = {srCarry, up.a, 1'b0} >> shAmt;

    always_comb
    begin
        result = '0;
        srNext = up.srIn;  // Untouched flags pass through
        case (up.opClass)
            execPkg::clsArith:
            begin
                if (isSub)
                    {srNext[execPkg::carryBit], result} = subDiff;
                else
                    {srNext[execPkg::carryBit], result} = addSum;
            end
            execPkg::clsLogic:
            begin
                case (up.opcode)
                    execPkg::opAnd:  result = up.a & up.op2;
                    execPkg::opNand: result = ~(up.a & up.op2);
                    execPkg::opOr:   result = up.a | up.op2;
                    execPkg::opNor:  result = ~(up.a | up.op2);
                    execPkg::opXor:  result = up.a ^ up.op2;
                    default:         result = ~(up.a ^ up.op2);
                endcase
            end
            execPkg::clsShift:
            begin
                case (up.opcode)
                    execPkg::opShl:  result = up.a << shAmt;
                    execPkg::opShr:  result = up.a >> shAmt;
                    execPkg::opShlC:
                    begin
                        result = shlWide[execPkg::dataWidth:1];
                        if (shAmt != '0)
                            srNext[execPkg::carryBit] = shlWide[execPkg::dataWidth+1];
                    end
                    default:
                    begin
                        result = shrWide[execPkg::dataWidth:1];  // SHRC
                        if (shAmt != '0)
                            srNext[execPkg::carryBit] = shrWide[0];
                    end
                endcase
            end
            execPkg::clsCompare:
            begin
                // Unsigned: 11 equal, 10 greater, 01 less
                srNext[execPkg::cmpHiBit] = (up.a >= up.op2);
                srNext[execPkg::cmpLoBit] = (up.a <= up.op2);
            end
            execPkg::clsStatus:
            begin
                case (up.opcode)
                    execPkg::opSor:  srNext = up.srIn | up.a[execPkg::srWidth-1:0];
                    execPkg::opSand: srNext = up.srIn & up.a[execPkg::srWidth-1:0];
                    default:
                        result = {{(execPkg::dataWidth - execPkg::srWidth){1'b0}}, up.srIn};
                endcase
            end
            execPkg::clsMove:
                result = up.op2;  // MOV and LDI
            default:
                result = '0;      // Jumps and NOP
        endcase
    end

    assign up.ready = !down.valid || down.ready;

    always_ff @(posedge clk)
    begin
        if (rst)
            down.valid <= 1'b0;
        else if (up.ready)
            down.valid <= up.valid;
    end

    always_ff @(posedge clk)
    begin
        if (up.valid && up.ready)
        begin
            down.opcode  <= up.opcode;
            down.opClass <= up.opClass;
            down.result  <= result;
            down.srNext  <= srNext;
            down.target  <= up.op2;
            down.srIn    <= up.srIn;
        end
    end

endmodule

//--- rtl/executeUnit.sv
`timescale 1ns/1ps

module executeUnit
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inValid,
    output logic                          inReady,
    input  logic [7:0]                    opcode,
    input  logic [execPkg::dataWidth-1:0] argA,
    input  logic [execPkg::dataWidth-1:0] argB,
    input  logic [execPkg::immWidth-1:0]  imm,
    input  logic [execPkg::srWidth-1:0]   srIn,
    output logic                          outValid,
    input  logic                          outReady,
    output logic [execPkg::dataWidth-1:0] wrData,
    output logic                          wrEn,
    output logic [execPkg::srWidth-1:0]   srOut,
    output logic                          srWrite,
    output execPkg::pcOp_e                pcOp,
    output logic [execPkg::dataWidth-1:0] pcTarget
);

    operandIf operandLink ();  // Decode to execute
    resultIf  resultLink ();   // Execute to PC control

    operandStage i_operandStage
    (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .inReady (inReady),
        .opcode  (opcode),
        .argA    (argA),
        .argB    (argB),
        .imm     (imm),
        .srIn    (srIn),
        .down    (operandLink.source)
    );

    executeStage i_executeStage
    (
        .clk  (clk),
        .rst  (rst),
        .up   (operandLink.sink),
        .down (resultLink.source)
    );

    pcControlStage i_pcControlStage
    (
        .clk      (clk),
        .rst      (rst),
        .outReady (outReady),
        .up       (resultLink.sink),
        .outValid (outValid),
        .wrData   (wrData),
        .wrEn     (wrEn),
        .srOut    (srOut),
        .srWrite  (srWrite),
        .pcOp     (pcOp),
        .pcTarget (pcTarget)
    );

endmodule

//--- rtl/operandStage.sv
`timescale 1ns/1ps

module operandStage
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inValid,
    output logic                          inReady,
    input  logic [7:0]                    opcode,
    input  logic [execPkg::dataWidth-1:0] argA,
    input  logic [execPkg::dataWidth-1:0] argB,
    input  logic [execPkg::immWidth-1:0]  imm,
    input  logic [execPkg::srWidth-1:0]   srIn,
    operandIf.source                      down
);

    execPkg::opcode_e              opDecoded;
    execPkg::opClass_e             clsDecoded;
    logic                          useImm;
    logic [execPkg::dataWidth-1:0] immExt;

    assign immExt  = {{(execPkg::dataWidth - execPkg::immWidth){1'b0}}, imm};
    assign inReady = !down.valid || down.ready;  // Empty or draining

    //////////////////////////////
    // Opcode decode
    //////////////////////////////
    always_comb
    begin
        case (opcode)
            execPkg::opAddIm, execPkg::opAddImC, execPkg::opAdd, execPkg::opAddC,
            execPkg::opSubIm, execPkg::opSubImC, execPkg::opSub, execPkg::opSubC,
            execPkg::opShl, execPkg::opShlC, execPkg::opShr, execPkg::opShrC,
            execPkg::opAnd, execPkg::opNand, execPkg::opOr, execPkg::opNor,
            execPkg::opXor, execPkg::opXnor, execPkg::opRjp, execPkg::opJp,
            execPkg::opJeq, execPkg::opJg, execPkg::opJl, execPkg::opJgeq,
            execPkg::opJleq, execPkg::opCp, execPkg::opCpi, execPkg::opLdi,
            execPkg::opMov, execPkg::opSor, execPkg::opSand, execPkg::opSld:
                opDecoded = execPkg::opcode_e'(opcode);
            default:
                opDecoded = execPkg::opNop;  // Unknown codes fall back to NOP
        endcase
    end

    always_comb
    begin
        case (opDecoded)
            execPkg::opAddIm, execPkg::opAddImC, execPkg::opAdd, execPkg::opAddC,
            execPkg::opSubIm, execPkg::opSubImC, execPkg::opSub, execPkg::opSubC:
                clsDecoded = execPkg::clsArith;
            execPkg::opAnd, execPkg::opNand, execPkg::opOr, execPkg::opNor,
            execPkg::opXor, execPkg::opXnor:
                clsDecoded = execPkg::clsLogic;
            execPkg::opShl, execPkg::opShlC, execPkg::opShr, execPkg::opShrC:
                clsDecoded = execPkg::clsShift;
            execPkg::opCp, execPkg::opCpi:
                clsDecoded = execPkg::clsCompare;
            execPkg::opRjp, execPkg::opJp, execPkg::opJeq, execPkg::opJg,
            execPkg::opJl, execPkg::opJgeq, execPkg::opJleq:
                clsDecoded = execPkg::clsJump;
            execPkg::opSor, execPkg::opSand, execPkg::opSld:
                clsDecoded = execPkg::clsStatus;
            execPkg::opMov, execPkg::opLdi:
                clsDecoded = execPkg::clsMove;
            default:
                clsDecoded = execPkg::clsNop;
        endcase
    end

    // Shifts and jumps always take the immediate
    assign useImm = (clsDecoded inside {execPkg::clsShift, execPkg::clsJump})
                 || (opDecoded inside {execPkg::opAddIm, execPkg::opAddImC,
                                       execPkg::opSubIm, execPkg::opSubImC,
                                       execPkg::opCpi, execPkg::opLdi});

    always_ff @(posedge clk)
    begin
        if (rst)
            down.valid <= 1'b0;
        else if (inReady)
            down.valid <= inValid;
    end

    always_ff @(posedge clk)
    begin
        if (inValid && inReady)
        begin
            down.opcode  <= opDecoded;
            down.opClass <= clsDecoded;
            down.a       <= argA;
            down.op2     <= useImm ? immExt : argB;
            down.srIn    <= srIn;
        end
    end

endmodule

//--- rtl/pcControlStage.sv
`timescale 1ns/1ps

module pcControlStage
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          outReady,
    resultIf.sink                         up,
    output logic                          outValid,
    output logic [execPkg::dataWidth-1:0] wrData,
    output logic                          wrEn,
    output logic [execPkg::srWidth-1:0]   srOut,
    output logic                          srWrite,
    output execPkg::pcOp_e                pcOp,
    output logic [execPkg::dataWidth-1:0] pcTarget
);

    logic                          cmpHi;
    logic                          cmpLo;
    logic                          taken;
    logic                          wrEnNext;
    logic                          srWriteNext;
    execPkg::pcOp_e                pcOpNext;
    logic [execPkg::dataWidth-1:0] targetNext;

    assign cmpHi = up.srIn[execPkg::cmpHiBit];
    assign cmpLo = up.srIn[execPkg::cmpLoBit];

    //////////////////////////////
    // Branch resolution
    //////////////////////////////
    always_comb
    begin
        case (up.opcode)
            execPkg::opJeq:  taken = cmpHi && cmpLo;
            execPkg::opJg:   taken = cmpHi && !cmpLo;
            execPkg::opJl:   taken = !cmpHi && cmpLo;
            execPkg::opJgeq: taken = cmpHi;
            execPkg::opJleq: taken = cmpLo;
            default:         taken = 1'b0;
        endcase
    end

    always_comb
    begin
        pcOpNext   = execPkg::pcInc;  // Not-taken jumps step too
        targetNext = up.target;
        if ((up.opcode == execPkg::opJp) || taken)
            pcOpNext = execPkg::pcSet;
        else if (up.opcode == execPkg::opRjp)
        begin
            pcOpNext   = execPkg::pcAdd;
            targetNext = up.target + 1'b1;  // Offset counted past the RJP itself
        end
    end

    assign wrEnNext    = (up.opClass inside {execPkg::clsArith, execPkg::clsLogic,
                                             execPkg::clsShift, execPkg::clsMove})
                      || (up.opcode == execPkg::opSld);
    assign srWriteNext = (up.opClass inside {execPkg::clsArith, execPkg::clsCompare})
                      || (up.opcode inside {execPkg::opSor, execPkg::opSand,
                                            execPkg::opShlC, execPkg::opShrC});

    assign up.ready = !outValid || outReady;

    always_ff @(posedge clk)
    begin
        if (rst)
            outValid <= 1'b0;
        else if (up.ready)
            outValid <= up.valid;
    end

    always_ff @(posedge clk)
    begin
        if (up.valid && up.ready)
        begin
            wrData   <= up.result;
            wrEn     <= wrEnNext;
            srOut    <= up.srNext;
            srWrite  <= srWriteNext;
            pcOp     <= pcOpNext;
            pcTarget <= targetNext;
        end
    end

endmodule

//--- rtl/stageIfs.sv
`timescale 1ns/1ps

// Decoded item, operand stage to execute stage
interface operandIf;
    logic                          valid;
    logic                          ready;
    execPkg::opcode_e              opcode;
    execPkg::opClass_e             opClass;
    logic [execPkg::dataWidth-1:0] a;
    logic [execPkg::dataWidth-1:0] op2;    // argB or extended immediate
    logic [execPkg::srWidth-1:0]   srIn;

    modport source
    (
        output valid,
        output opcode,
        output opClass,
        output a,
        output op2,
        output srIn,
        input  ready
    );

    modport sink
    (
        input  valid,
        input  opcode,
        input  opClass,
        input  a,
        input  op2,
        input  srIn,
        output ready
    );
endinterface

// Computed item, execute stage to PC control stage
interface resultIf;
    logic                          valid;
    logic                          ready;
    execPkg::opcode_e              opcode;
    execPkg::opClass_e             opClass;
    logic [execPkg::dataWidth-1:0] result;
    logic [execPkg::srWidth-1:0]   srNext;
    logic [execPkg::dataWidth-1:0] target;  // Jump target, op2 unchanged
    logic [execPkg::srWidth-1:0]   srIn;    // Flags seen by conditional jumps

    modport source
    (
        output valid,
        output opcode,
        output opClass,
        output result,
        output srNext,
        output target,
        output srIn,
        input  ready
    );

    modport sink
    (
        input  valid,
        input  opcode,
        input  opClass,
        input  result,
        input  srNext,
        input  target,
        input  srIn,
        output ready
    );
endinterface

//--- tb.f
+incdir+verification
rtl/execPkg.sv
rtl/stageIfs.sv
rtl/operandStage.sv
rtl/executeStage.sv
rtl/pcControlStage.sv
rtl/executeUnit.sv
verification/executeUnitTb.sv

//--- verification/execModel.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// One expected output transfer
typedef struct packed {
    logic [7:0]                    op;
    logic [execPkg::dataWidth-1:0] wrData;
    logic                          wrEn;
    logic [execPkg::srWidth-1:0]   srOut;
    logic                          srWrite;
    execPkg::pcOp_e                pcOp;
    logic [execPkg::dataWidth-1:0] pcTarget;
} expItem_t;

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Bit by bit; the carry fills only the first vacated position
function automatic logic [32:0] shiftCarry(input logic [31:0] a, input logic cin,
                                           input logic [4:0] n, input logic left);
    logic [31:0] v;
    logic        c;
    logic        fill;
    int          i;
    v = a;
    c = cin;
    fill = cin;
    for (i = 0; i < int'(n); i++)
    begin
        if (left)
        begin
            c = v[31];
            v = {v[30:0], fill};
        end
        else
        begin
            c = v[0];
            v = {fill, v[31:1]};
        end
        fill = 1'b0;
    end
    return {c, v};
endfunction

function automatic expItem_t expectedOutput(input logic [7:0] op, input logic [31:0] a,
                                            input logic [31:0] b, input logic [23:0] imm,
                                            input logic [7:0] sr);
    expItem_t        e;
    logic [31:0]     op2;
    logic            cin;
    logic [32:0]     sh;
    longint unsigned wide;
    op2 = (op inside {execPkg::opAddIm, execPkg::opAddImC, execPkg::opSubIm,
                      execPkg::opSubImC, execPkg::opShl, execPkg::opShlC, execPkg::opShr,
                      execPkg::opShrC, execPkg::opCpi, execPkg::opLdi, execPkg::opJp,
                      execPkg::opRjp, execPkg::opJeq, execPkg::opJg, execPkg::opJl,
                      execPkg::opJgeq, execPkg::opJleq}) ? {8'd0, imm} : b;
    cin = (op inside {execPkg::opAddC, execPkg::opAddImC, execPkg::opSubC,
                      execPkg::opSubImC}) && sr[execPkg::carryBit];
    e = '0;
    e.op = op;
    e.srOut = sr;                   // Untouched flags pass through
    e.pcOp = execPkg::pcInc;
    e.pcTarget = op2;
    case (op)
        execPkg::opAdd, execPkg::opAddC, execPkg::opAddIm, execPkg::opAddImC:
        begin
            wide = 64'(a) + 64'(op2) + 64'(cin);
            e.wrData = wide[31:0];
            e.srOut[execPkg::carryBit] = wide[32];
        end
        execPkg::opSub, execPkg::opSubC, execPkg::opSubIm, execPkg::opSubImC:
        begin
            wide = 64'(op2) + 64'(cin);
            e.wrData = a - wide[31:0];
            e.srOut[execPkg::carryBit] = (64'(a) < wide);  // Borrow
        end
        execPkg::opAnd:  e.wrData = a & op2;
        execPkg::opNand: e.wrData = ~(a & op2);
        execPkg::opOr:   e.wrData = a | op2;
        execPkg::opNor:  e.wrData = ~(a | op2);
        execPkg::opXor:  e.wrData = a ^ op2;
        execPkg::opXnor: e.wrData = ~(a ^ op2);
        execPkg::opShl:  e.wrData = a << op2[4:0];
        execPkg::opShr:  e.wrData = a >> op2[4:0];
        execPkg::opShlC, execPkg::opShrC:
        begin
            sh = shiftCarry(a, sr[execPkg::carryBit], op2[4:0], op == execPkg::opShlC);
            e.wrData = sh[31:0];
            e.srOut[execPkg::carryBit] = sh[32];
        end
        execPkg::opCp, execPkg::opCpi:
            e.srOut[1:0] = (a == op2) ? 2'b11 : ((a > op2) ? 2'b10 : 2'b01);
        execPkg::opJp:   e.pcOp = execPkg::pcSet;
        execPkg::opRjp:
        begin
            e.pcOp = execPkg::pcAdd;
            e.pcTarget = op2 + 32'd1;
        end
        execPkg::opJeq:  e.pcOp = (sr[1:0] == 2'b11) ? execPkg::pcSet : execPkg::pcInc;
        execPkg::opJg:   e.pcOp = (sr[1:0] == 2'b10) ? execPkg::pcSet : execPkg::pcInc;
        execPkg::opJl:   e.pcOp = (sr[1:0] == 2'b01) ? execPkg::pcSet : execPkg::pcInc;
        execPkg::opJgeq: e.pcOp = sr[1] ? execPkg::pcSet : execPkg::pcInc;
        execPkg::opJleq: e.pcOp = sr[0] ? execPkg::pcSet : execPkg::pcInc;
        execPkg::opMov, execPkg::opLdi: e.wrData = op2;
        execPkg::opSor:  e.srOut = sr | a[7:0];
        execPkg::opSand: e.srOut = sr & a[7:0];
        execPkg::opSld:  e.wrData = {24'd0, sr};
        default:         e.op = op;  // Unknown codes act as NOP
    endcase
    e.wrEn = (op inside {[8'd1:8'd8], [8'd13:8'd22], execPkg::opMov, execPkg::opLdi,
                         execPkg::opSld});
    e.srWrite = (op inside {[8'd1:8'd8], execPkg::opCp, execPkg::opCpi, execPkg::opSor,
                            execPkg::opSand, execPkg::opShlC, execPkg::opShrC});
    return e;
endfunction

`endif

//--- verification/executeUnitTb.sv
`timescale 1ns/1ps

module executeUnitTb;

    `include "execModel.svh"

    logic                          clk;
    logic                          rst;
    logic                          inValid;
    logic                          inReady;
    logic [7:0]                    opcode;
    logic [execPkg::dataWidth-1:0] argA;
    logic [execPkg::dataWidth-1:0] argB;
    logic [execPkg::immWidth-1:0]  imm;
    logic [execPkg::srWidth-1:0]   srIn;
    logic                          outValid;
    logic                          outReady;
    logic [execPkg::dataWidth-1:0] wrData;
    logic                          wrEn;
    logic [execPkg::srWidth-1:0]   srOut;
    logic                          srWrite;
    execPkg::pcOp_e                pcOp;
    logic [execPkg::dataWidth-1:0] pcTarget;

    logic [31:0] rngState;
    expItem_t    expQ[$];   // Accepted items not yet seen at the output
    int          errors;
    int          checks;
    int          sentCount;
    int          gotCount;
    int          testsRun;
    int          testsFailed;
    int          errBefore;
    int          i;

    localparam logic [7:0] opList [37] = '{
        8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'd8,            // Arithmetic
        8'd17, 8'd18, 8'd19, 8'd20, 8'd21, 8'd22,                  // Logic
        8'd13, 8'd14, 8'd15, 8'd16,                                // Shifts
        8'd31, 8'd33, 8'd23, 8'd24, 8'd26, 8'd27, 8'd28, 8'd29, 8'd30,
        8'd37, 8'd38, 8'd44, 8'd45, 8'd46,                         // Moves and status
        8'd0, 8'd9, 8'd25, 8'd200, 8'd255                          // Unknown, NOP
    };

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    executeUnit i_executeUnit
    (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .opcode   (opcode),
        .argA     (argA),
        .argB     (argB),
        .imm      (imm),
        .srIn     (srIn),
        .outValid (outValid),
        .outReady (outReady),
        .wrData   (wrData),
        .wrEn     (wrEn),
        .srOut    (srOut),
        .srWrite  (srWrite),
        .pcOp     (pcOp),
        .pcTarget (pcTarget)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic reportTest(input string name, input int errStart);
        testsRun++;
        if (errors == errStart)
            $display("%s: ok", name);
        else
        begin
            testsFailed++;
            $display("%s: FAILED with %0d errors", name, errors - errStart);
        end
    endtask

    task automatic checkOutput();
        expItem_t e;
        string    tag;
        if (expQ.size() == 0)
        begin
            errors++;
            $display("%0d ns: output transfer with no item in flight", $time);
        end
        else
        begin
            e = expQ.pop_front();
            gotCount++;
            tag = $sformatf(" of opcode %0d", e.op);
            compare({"wrEn", tag}, 64'(wrEn), 64'(e.wrEn));
            compare({"srWrite", tag}, 64'(srWrite), 64'(e.srWrite));
            compare({"srOut", tag}, 64'(srOut), 64'(e.srOut));
            compare({"pcOp", tag}, 64'(pcOp), 64'(e.pcOp));
            if (e.wrEn)
                compare({"wrData", tag}, 64'(wrData), 64'(e.wrData));
            if (e.pcOp != execPkg::pcInc)
                compare({"pcTarget", tag}, 64'(pcTarget), 64'(e.pcTarget));
        end
    endtask

    // Both handshakes seen with pre-edge values
    always @(posedge clk)
    begin
        if (!rst && inValid && inReady)
        begin
            expQ.push_back(expectedOutput(opcode, argA, argB, imm, srIn));
            sentCount++;
        end
        if (!rst && outValid && outReady)
            checkOutput();
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic newItem(input int first, input int span);
        logic [31:0] r;
        logic [31:0] b;
        logic [31:0] x;
        r = nextRand();
        b = nextRand();
        x = nextRand();
        if (r[13:11] == 3'd0)
            x[4:0] = 5'd0;  // Zero shift amount now and then
        opcode <= opList[first + int'(r[15:0]) % span];
        argB   <= b;
        imm    <= x[23:0];
        srIn   <= x[31:24];
        case (r[18:16])
            3'd0:    argA <= b;             // Equal operands for CP
            3'd1:    argA <= {8'd0, x[23:0]};  // Equal operands for CPI
            default: argA <= nextRand();
        endcase
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        do
        begin
            @(negedge clk);
            guard++;
        end
        while ((expQ.size() != 0 || outValid) && guard < 100);
        if (expQ.size() != 0 || outValid)
        begin
            errors++;
            $display("timeout: pipeline did not drain, %0d items left", expQ.size());
        end
    endtask

    task automatic runItems(input string name, input int first, input int span, input int count);
        int          errStart;
        int          accepted;
        int          guard;
        logic [31:0] r;
        errStart = errors;
        accepted = 0;
        guard = 0;
        while (accepted < count && guard < count * 50)
        begin
            @(posedge clk);
            guard++;
            if (inValid && inReady)
                accepted++;
            r = nextRand();
            outReady <= (r[1:0] != 2'b00);  // Stall about one cycle in four
            if (!inValid || inReady)
            begin
                inValid <= (accepted < count) && (r[3:2] != 2'b00);
                newItem(first, span);
            end
        end
        if (accepted < count)
        begin
            errors++;
            $display("timeout: %s accepted only %0d of %0d items", name, accepted, count);
        end
        inValid  <= 1'b0;
        outReady <= 1'b1;
        drain();
        reportTest(name, errStart);
    endtask

    task automatic latencyCheck();
        int   errStart;
        int   guard;
        int   cycles;
        int   k;
        logic accepted;
        errStart = errors;
        for (k = 0; k < 4; k++)
        begin
            @(posedge clk);
            outReady <= 1'b1;
            inValid  <= 1'b1;
            newItem(0, 37);
            accepted = 1'b0;
            guard = 0;
            while (!accepted && guard < 20)
            begin
                @(posedge clk);
                guard++;
                accepted = inValid && inReady;
            end
            inValid <= 1'b0;
            if (!accepted)
            begin
                errors++;
                $display("timeout: latency item was not accepted");
            end
            cycles = 0;
            do
            begin
                @(negedge clk);
                cycles++;
            end
            while (!outValid && cycles < 20);
            compare("latency in cycles", 64'(cycles), 64'd3);  // Acceptance edge counts as one
        end
        drain();
        reportTest("latency with outReady high", errStart);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial
    begin
        rngState    = 32'd63;
        errors      = 0;
        checks      = 0;
        sentCount   = 0;
        gotCount    = 0;
        testsRun    = 0;
        testsFailed = 0;
        rst         = 1'b1;
        inValid     = 1'b0;
        outReady    = 1'b0;
        opcode      = 8'd255;
        argA        = '0;
        argB        = '0;
        imm         = '0;
        srIn        = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        errBefore = errors;
        for (i = 0; i < 10; i++)
        begin
            @(negedge clk);
            compare("outValid while idle", 64'(outValid), 64'd0);
        end
        reportTest("reset and idle", errBefore);

        runItems("add and subtract", 0, 8, 200);
        runItems("logic and shifts", 8, 10, 200);
        runItems("compares and jumps", 18, 9, 200);
        runItems("moves, status and unknown opcodes", 27, 10, 200);
        runItems("ordering under back-pressure", 0, 37, 400);
        latencyCheck();

        $display("tests %0d, failed %0d, items in %0d, items out %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, sentCount, gotCount, checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
